//--- sources.f
+incdir+include
src/decd_pkg.sv
src/decd_base_rv32i.sv
src/decd_priv_chk.sv
src/decd_xocc.sv
src/decd_stage.sv
src/idu_decd_top.sv
dv/idu_decd_assert.sv
dv/idu_decd_tb.sv

//--- Bender.yml
package:
  name: idu_decd

export_include_dirs:
  - include

sources:
  - src/decd_pkg.sv
  - src/decd_base_rv32i.sv
  - src/decd_priv_chk.sv
  - src/decd_xocc.sv
  - src/decd_stage.sv
  - src/idu_decd_top.sv
  - target: test
    files:
      - dv/idu_decd_assert.sv
      - dv/idu_decd_tb.sv

//--- dv/idu_decd_tb.sv
/* Decode stage testbench
   Table of instructions with expected decode results, checked one cycle later */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module idu_decd_tb;
  import decd_pkg::*;

  localparam int CLK_PERIOD = 4;

  // One table row, mode is {mach_mode, isa_ext_en, dbg_on, fetch_expt}
  // opv is {rs1, rs2, rd} valid, flags is {imm_vld, ill, bju_pc, push, pop}
  typedef struct packed {
    logic                    vld;
    logic [`DECD_INST_W-1:0] inst;
    logic [3:0]              mode;
    logic [4:0]              unit;
    logic [1:0]              func;
    logic [2:0]              sub;
    logic [2:0]              opv;
    logic [31:0]             imm;
    logic [4:0]              flags;
  } row_t;

  logic                    clk;
  logic                    arst_n;
  logic                    inst_vld;
  logic [`DECD_INST_W-1:0] inst;
  logic                    fetch_expt;
  logic                    mach_mode;
  logic                    isa_ext_en;
  logic                    dbg_on;
  logic                    out_vld;
  unit_sel_t               unit_sel;
  xocc_func_t              xocc_func;
  xocc_sub_t               xocc_sub;
  logic [`DECD_IDX_W-1:0]  rs1_idx;
  logic [`DECD_IDX_W-1:0]  rs2_idx;
  logic [`DECD_IDX_W-1:0]  rd_idx;
  logic                    rs1_vld;
  logic                    rs2_vld;
  logic                    rd_vld;
  logic [31:0]             imm;
  logic                    imm_vld;
  logic                    ill_expt;
  logic                    bju_use_pc;
  logic                    ipush_vld;
  logic                    ipop_vld;

  row_t table_q[$];
  row_t idle_row;
  bit   rows_ready;
  int   cur_row;

  idu_decd_top i_dut (.*);

  bind idu_decd_top idu_decd_assert i_assert (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_row(input logic vld, input logic [31:0] code, input logic [3:0] mode,
                         input logic [4:0] unit, input logic [1:0] func, input logic [2:0] sub,
                         input logic [2:0] opv, input logic [31:0] exp_imm,
                         input logic [4:0] flags);
    row_t r;
    r = {vld, code, mode, unit, func, sub, opv, exp_imm, flags};
    table_q.push_back(r);
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: row %0d %s is %h, expected %h", $time, cur_row, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "decode output check failed");
    end
  endtask

  task automatic drive_row(input row_t r);
    inst_vld <= r.vld;
    inst     <= r.inst;
    {mach_mode, isa_ext_en, dbg_on, fetch_expt} <= r.mode;
  endtask

  task automatic check_row(input row_t r);
    logic [4:0] exp_rs1;
    logic [4:0] exp_rs2;
    logic [4:0] exp_rd;
    // Register fields pass through on every valid instruction
    exp_rs1 = r.vld ? r.inst[19:15] : 5'd0;
    exp_rs2 = r.vld ? r.inst[24:20] : 5'd0;
    exp_rd  = r.vld ? r.inst[11:7] : 5'd0;
    check_val("out_vld", out_vld, r.vld);
    check_val("unit_sel", unit_sel, r.unit);
    check_val("xocc_func", xocc_func, r.func);
    check_val("xocc_sub", xocc_sub, r.sub);
    check_val("rs1_idx", rs1_idx, exp_rs1);
    check_val("rs2_idx", rs2_idx, exp_rs2);
    check_val("rd_idx", rd_idx, exp_rd);
    check_val("rs1/rs2/rd valids", {rs1_vld, rs2_vld, rd_vld}, r.opv);
    check_val("imm", imm, r.imm);
    check_val("imm_vld", imm_vld, r.flags[4]);
    check_val("ill_expt", ill_expt, r.flags[3]);
    check_val("bju_use_pc", bju_use_pc, r.flags[2]);
    check_val("ipush_vld", ipush_vld, r.flags[1]);
    check_val("ipop_vld", ipop_vld, r.flags[0]);
  endtask

  // ====================
  // Stimulus table
  // ====================
  task automatic fill_table();
    // Base set
    add_row(1'b1, 32'h002081B3, 4'b0000, UNIT_ALU, XOCC_NONE, SUB_NONE, 3'b111, 32'h0, 5'b00000);
    add_row(1'b1, 32'hFFF30293, 4'b0000, UNIT_ALU, XOCC_NONE, SUB_NONE, 3'b101, 32'hFFFFFFFF,
            5'b10000);
    add_row(1'b1, 32'h00812383, 4'b0000, UNIT_LSU, XOCC_NONE, SUB_NONE, 3'b101, 32'h8, 5'b10000);
    add_row(1'b1, 32'hFE952E23, 4'b0000, UNIT_LSU, XOCC_NONE, SUB_NONE, 3'b110, 32'hFFFFFFFC,
            5'b10000);
    add_row(1'b1, 32'hFE208CE3, 4'b0000, UNIT_BJU, XOCC_NONE, SUB_NONE, 3'b110, 32'hFFFFFFF8,
            5'b10100);
    add_row(1'b1, 32'h12345237, 4'b0000, UNIT_ALU, XOCC_NONE, SUB_NONE, 3'b001, 32'h12345000,
            5'b10000);
    add_row(1'b1, 32'h010000EF, 4'b0000, UNIT_BJU, XOCC_NONE, SUB_NONE, 3'b001, 32'h10, 5'b10100);
    add_row(1'b1, 32'h00008067, 4'b0000, UNIT_BJU, XOCC_NONE, SUB_NONE, 3'b101, 32'h0, 5'b10000);
    // Single idle cycle
    add_row(1'b0, 32'h0, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0, 5'b00000);
    // Coprocessor, rs1 x3, rd x4, imm -2
    add_row(1'b1, 32'hFFE1825B, 4'b0000, UNIT_XOCC, XOCC_NORM, SUB_PUSH_RDY, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1925B, 4'b0000, UNIT_XOCC, XOCC_NORM, SUB_POP_RDY, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1D25B, 4'b0000, UNIT_XOCC, XOCC_NORM, SUB_READ_RSP, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1A25B, 4'b0000, UNIT_XOCC, XOCC_DLY, SUB_PUSH_CMD, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1C25B, 4'b0000, UNIT_XOCC, XOCC_DLY, SUB_WRITE_CMD, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1B25B, 4'b0000, UNIT_XOCC, XOCC_DLY, SUB_POP_RSP, 3'b101, 32'hFFFFFFFE,
            5'b10000);
    add_row(1'b1, 32'hFFE1E25B, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'hFFE1E25B,
            5'b11000);
    // Illegal encodings, trap value in imm
    add_row(1'b1, 32'h422081B3, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h422081B3,
            5'b11000);
    add_row(1'b1, 32'h6020D1B3, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h6020D1B3,
            5'b11000);
    add_row(1'b1, 32'h00813383, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h00813383,
            5'b11000);
    add_row(1'b1, 32'hABCD4501, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h00004501,
            5'b11000);
    add_row(1'b1, 32'h00A5807F, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h00A5807F,
            5'b11000);
    // DRET outside and inside debug mode
    add_row(1'b1, 32'h7B200073, 4'b0000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h7B200073,
            5'b11000);
    add_row(1'b1, 32'h7B200073, 4'b0010, UNIT_CP0, XOCC_NONE, SUB_NONE, 3'b000, 32'h000007B2,
            5'b10000);
    // Branch in debug mode keeps its unit but traps
    add_row(1'b1, 32'hFE208CE3, 4'b0010, UNIT_BJU, XOCC_NONE, SUB_NONE, 3'b110, 32'hFE208CE3,
            5'b11100);
    // Hardware stack push and pop
    add_row(1'b1, 32'h0040000B, 4'b1100, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0, 5'b00010);
    add_row(1'b1, 32'h0050000B, 4'b0110, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0, 5'b00001);
    add_row(1'b1, 32'h0040000B, 4'b1101, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0, 5'b00000);
    add_row(1'b1, 32'h0040000B, 4'b1000, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0040000B,
            5'b11000);
    add_row(1'b1, 32'h0050000B, 4'b0100, UNIT_NONE, XOCC_NONE, SUB_NONE, 3'b000, 32'h0050000B,
            5'b11000);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial
  begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_vld   = 1'b0;
    inst       = '0;
    fetch_expt = 1'b0;
    mach_mode  = 1'b0;
    isa_ext_en = 1'b0;
    dbg_on     = 1'b0;
    idle_row   = '0;
    cur_row    = -1;
    fill_table();
    rows_ready = 1'b1;

    // Outputs must be cleared while reset is held
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_row(idle_row);
    @(posedge clk);
    arst_n <= 1'b1;

    // Row k goes in, row k-1 comes out on the same edge
    for (int k = 0; k <= table_q.size(); k++)
    begin
      @(posedge clk);
      if (k < table_q.size())
        drive_row(table_q[k]);
      else
        drive_row(idle_row);
      @(negedge clk);
      if (k > 0)
      begin
        cur_row = k - 1;
        check_row(table_q[k - 1]);
      end
    end

    $display("** PASS **");
    $finish;
  end

  // Bound checker failures
  initial
  begin
    wait (i_dut.i_assert.fail_cnt != 0);
    $display("Assertion failure in the bound output checker at %0t", $time);
    $display("** FAIL **");
    $fatal(1, "bound assertion failed");
  end

  // Watchdog
  initial
  begin
    wait (rows_ready);
    #((table_q.size() + 20) * CLK_PERIOD);
    $display("Timeout: the decode table did not finish in time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- dv/idu_decd_assert.sv
/* Decode output assertions
   Bound to the decode top, checks unit select, trap immediate and stack flags */
`timescale 1ns/1ps
`default_nettype none

module idu_decd_assert (
  input logic                clk,
  input logic                arst_n,
  input logic                out_vld,
  input decd_pkg::unit_sel_t unit_sel,
  input logic                imm_vld,
  input logic                ill_expt,
  input logic                ipush_vld,
  input logic                ipop_vld
);
  import decd_pkg::*;

  // Count of failed assertions, watched by the testbench
  int unsigned fail_cnt = 0;

  a_unit_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(unit_sel))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("unit_sel %b selects more than one unit", unit_sel);
  end

  // Idle cycles carry no unit
  a_idle_unit: assert property (@(posedge clk) disable iff (!arst_n)
    !out_vld |-> unit_sel == UNIT_NONE)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("unit_sel %b set while out_vld is low", unit_sel);
  end

  // Trap value always rides on imm
  a_ill_imm: assert property (@(posedge clk) disable iff (!arst_n) ill_expt |-> imm_vld)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("ill_expt set without imm_vld");
  end

  a_push_pop: assert property (@(posedge clk) disable iff (!arst_n) !(ipush_vld && ipop_vld))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("ipush_vld and ipop_vld both high");
  end

endmodule

`default_nettype wire

//--- src/idu_decd_top.sv
/* Instruction decode top
   Base, legality and coprocessor decoders feeding the stage register */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module idu_decd_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    inst_vld,
  input  logic [`DECD_INST_W-1:0] inst,
  input  logic                    fetch_expt,
  input  logic                    mach_mode,
  input  logic                    isa_ext_en,
  input  logic                    dbg_on,
  output logic                    out_vld,
  output decd_pkg::unit_sel_t     unit_sel,
  output decd_pkg::xocc_func_t    xocc_func,
  output decd_pkg::xocc_sub_t     xocc_sub,
  output logic [`DECD_IDX_W-1:0]  rs1_idx,
  output logic [`DECD_IDX_W-1:0]  rs2_idx,
  output logic [`DECD_IDX_W-1:0]  rd_idx,
  output logic                    rs1_vld,
  output logic                    rs2_vld,
  output logic                    rd_vld,
  output logic [31:0]             imm,
  output logic                    imm_vld,
  output logic                    ill_expt,
  output logic                    bju_use_pc,
  output logic                    ipush_vld,
  output logic                    ipop_vld
);
  import decd_pkg::*;

  unit_sel_t   base_unit;
  logic        base_rs1_vld;
  logic        base_rs2_vld;
  logic        base_rd_vld;
  logic [31:0] base_imm;
  logic        base_imm_vld;
  logic        ill32;
  logic        ipush_in;
  logic        ipop_in;
  logic        x_hit;
  xocc_func_t  x_func;
  xocc_sub_t   x_sub;
  logic [31:0] x_imm;
  logic        x_ill;

  decd_base_rv32i i_base (
    .inst    (inst),
    .unit    (base_unit),
    .rs1_vld (base_rs1_vld),
    .rs2_vld (base_rs2_vld),
    .rd_vld  (base_rd_vld),
    .imm     (base_imm),
    .imm_vld (base_imm_vld)
  );

  decd_priv_chk i_priv (
    .inst       (inst),
    .mach_mode  (mach_mode),
    .isa_ext_en (isa_ext_en),
    .dbg_on     (dbg_on),
    .fetch_expt (fetch_expt),
    .ill32      (ill32),
    .ipush_vld  (ipush_in),
    .ipop_vld   (ipop_in)
  );

  decd_xocc i_xocc (
    .inst (inst),
    .hit  (x_hit),
    .func (x_func),
    .sub  (x_sub),
    .imm  (x_imm),
    .ill  (x_ill)
  );

  // Stage ports carry the same names as the nets above
  decd_stage i_stage (.*);

endmodule

`default_nettype wire

//--- src/decd_stage.sv
/* Decode merge and output register
   Picks the decoder result, applies the debug rule and registers it */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module decd_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    inst_vld,
  input  logic [`DECD_INST_W-1:0] inst,
  input  logic                    dbg_on,
  input  decd_pkg::unit_sel_t     base_unit,
  input  logic                    base_rs1_vld,
  input  logic                    base_rs2_vld,
  input  logic                    base_rd_vld,
  input  logic [31:0]             base_imm,
  input  logic                    base_imm_vld,
  input  logic                    ill32,
  input  logic                    x_hit,
  input  decd_pkg::xocc_func_t    x_func,
  input  decd_pkg::xocc_sub_t     x_sub,
  input  logic [31:0]             x_imm,
  input  logic                    x_ill,
  input  logic                    ipush_in,
  input  logic                    ipop_in,
  output logic                    out_vld,
  output decd_pkg::unit_sel_t     unit_sel,
  output decd_pkg::xocc_func_t    xocc_func,
  output decd_pkg::xocc_sub_t     xocc_sub,
  output logic [`DECD_IDX_W-1:0]  rs1_idx,
  output logic [`DECD_IDX_W-1:0]  rs2_idx,
  output logic [`DECD_IDX_W-1:0]  rd_idx,
  output logic                    rs1_vld,
  output logic                    rs2_vld,
  output logic                    rd_vld,
  output logic [31:0]             imm,
  output logic                    imm_vld,
  output logic                    ill_expt,
  output logic                    bju_use_pc,
  output logic                    ipush_vld,
  output logic                    ipop_vld
);
  import decd_pkg::*;

  logic        is_32;
  unit_sel_t   sel_unit;
  xocc_func_t  sel_func;
  xocc_sub_t   sel_sub;
  logic        sel_rs1_vld;
  logic        sel_rs2_vld;
  logic        sel_rd_vld;
  logic [31:0] sel_imm;
  logic        sel_imm_vld;
  logic        dec_ill;
  logic        ill_nxt;
  logic [31:0] inst_code;

  assign is_32 = &inst[1:0];

  // ====================
  // Source select
  // ====================
  // Everything stays zero on an idle cycle
  always_comb
  begin
    sel_unit    = UNIT_NONE;
    sel_func    = XOCC_NONE;
    sel_sub     = SUB_NONE;
    sel_rs1_vld = 1'b0;
    sel_rs2_vld = 1'b0;
    sel_rd_vld  = 1'b0;
    sel_imm     = 32'h0;
    sel_imm_vld = 1'b0;
    dec_ill     = 1'b0;
    if (inst_vld)
    begin
      // 16-bit code falls through as illegal
      dec_ill = 1'b1;
      if (x_hit)
      begin
        dec_ill = x_ill;
        if (!x_ill)
        begin
          sel_unit    = UNIT_XOCC;
          sel_func    = x_func;
          sel_sub     = x_sub;
          sel_rs1_vld = 1'b1;
          sel_rd_vld  = 1'b1;
          sel_imm     = x_imm;
          sel_imm_vld = 1'b1;
        end
      end
      else if (is_32)
      begin
        dec_ill = ill32;
        if (!ill32)
        begin
          sel_unit    = base_unit;
          sel_rs1_vld = base_rs1_vld;
          sel_rs2_vld = base_rs2_vld;
          sel_rd_vld  = base_rd_vld;
          sel_imm     = base_imm;
          sel_imm_vld = base_imm_vld;
        end
      end
    end
  end

  // Branch unit is off limits in debug mode, unit select is kept
  assign ill_nxt   = dec_ill || (sel_unit == UNIT_BJU && dbg_on);
  // Trap value, upper half cleared for 16-bit code
  assign inst_code = {is_32 ? inst[31:16] : 16'h0000, inst[15:0]};

  // ====================
  // Output register
  // ====================
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_vld    <= 1'b0;
      unit_sel   <= UNIT_NONE;
      xocc_func  <= XOCC_NONE;
      xocc_sub   <= SUB_NONE;
      rs1_idx    <= '0;
      rs2_idx    <= '0;
      rd_idx     <= '0;
      rs1_vld    <= 1'b0;
      rs2_vld    <= 1'b0;
      rd_vld     <= 1'b0;
      imm        <= 32'h0;
      imm_vld    <= 1'b0;
      ill_expt   <= 1'b0;
      bju_use_pc <= 1'b0;
      ipush_vld  <= 1'b0;
      ipop_vld   <= 1'b0;
    end
    else
    begin
      out_vld    <= inst_vld;
      unit_sel   <= sel_unit;
      xocc_func  <= sel_func;
      xocc_sub   <= sel_sub;
      rs1_idx    <= inst_vld ? inst[`DECD_RS1_LSB +: `DECD_IDX_W] : '0;
      rs2_idx    <= inst_vld ? inst[`DECD_RS2_LSB +: `DECD_IDX_W] : '0;
      rd_idx     <= inst_vld ? inst[`DECD_RD_LSB +: `DECD_IDX_W] : '0;
      rs1_vld    <= sel_rs1_vld;
      rs2_vld    <= sel_rs2_vld;
      rd_vld     <= sel_rd_vld;
      imm        <= ill_nxt ? inst_code : sel_imm;
      imm_vld    <= ill_nxt || sel_imm_vld;
      ill_expt   <= ill_nxt;
      bju_use_pc <= sel_unit == UNIT_BJU && inst[6:0] != `DECD_OP_JALR;
      ipush_vld  <= inst_vld && ipush_in;
      ipop_vld   <= inst_vld && ipop_in;
    end
  end

endmodule

`default_nettype wire

//--- src/decd_xocc.sv
/* Coprocessor instruction decoder
   Function class, sub-function, immediate and legality of custom-2 */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module decd_xocc (
  input  logic [`DECD_INST_W-1:0] inst,
  output logic                    hit,
  output decd_pkg::xocc_func_t    func,
  output decd_pkg::xocc_sub_t     sub,
  output logic [31:0]             imm,
  output logic                    ill
);
  import decd_pkg::*;

  assign hit = inst[6:0] == `DECD_OP_XOCC;
  assign imm = {{20{inst[31]}}, inst[31:20]};

  always_comb
  begin
    func = XOCC_NONE;
    sub  = SUB_NONE;
    if (hit)
    begin
      case (inst[14:12])
        3'b000:
        begin
          func = XOCC_NORM;
          sub  = SUB_PUSH_RDY;
        end
        3'b001:
        begin
          func = XOCC_NORM;
          sub  = SUB_POP_RDY;
        end
        3'b101:
        begin
          func = XOCC_NORM;
          sub  = SUB_READ_RSP;
        end
        3'b010:
        begin
          func = XOCC_DLY;
          sub  = SUB_PUSH_CMD;
        end
        3'b100:
        begin
          func = XOCC_DLY;
          sub  = SUB_WRITE_CMD;
        end
        3'b011:
        begin
          func = XOCC_DLY;
          sub  = SUB_POP_RSP;
        end
        default: func = XOCC_NONE;
      endcase
    end
  end

  // funct3 110 and 111 select nothing
  assign ill = hit && sub == SUB_NONE;

endmodule

`default_nettype wire

//--- src/decd_priv_chk.sv
/* Base instruction legality check
   Encoding table, privilege rules and hardware-stack push/pop detect */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module decd_priv_chk (
  input  logic [`DECD_INST_W-1:0] inst,
  input  logic                    mach_mode,
  input  logic                    isa_ext_en,
  input  logic                    dbg_on,
  input  logic                    fetch_expt,
  output logic                    ill32,
  output logic                    ipush_vld,
  output logic                    ipop_vld
);
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;
  logic        sys_clean;
  logic        sys_known;
  logic        hstk_base;
  logic        hstk_priv;
  logic        push_code;
  logic        pop_code;
  logic        legal;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign funct12 = inst[31:20];

  // rs1, funct3 and rd all zero
  assign sys_clean = inst[19:7] == 13'h0000;
  // ECALL, EBREAK, WFI, MRET and DRET in debug mode only
  assign sys_known = funct12 == 12'h000 || funct12 == 12'h001 || funct12 == 12'h105
                  || funct12 == 12'h302 || (funct12 == 12'h7b2 && dbg_on);

  // ====================
  // Hardware stack
  // ====================
  assign hstk_base = opcode == `DECD_OP_HSTK && funct7 == 7'h00 && sys_clean;
  assign push_code = hstk_base && inst[24:20] == `DECD_RS2_IPUSH;
  assign pop_code  = hstk_base && inst[24:20] == `DECD_RS2_IPOP;
  assign hstk_priv = isa_ext_en && (mach_mode || dbg_on);

  always_comb
  begin
    case (opcode)
      `DECD_OP_REG:    legal = funct7 == 7'b0000000
                            || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      `DECD_OP_IMM:    legal = (funct3 == 3'b001) ? funct7 == 7'b0000000
                             : (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000)
                             : 1'b1;
      `DECD_OP_LOAD:   legal = funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111;
      `DECD_OP_STORE:  legal = funct3 <= 3'b010;
      `DECD_OP_BRANCH: legal = funct3 != 3'b010 && funct3 != 3'b011;
      `DECD_OP_JALR:   legal = funct3 == 3'b000;
      `DECD_OP_LUI, `DECD_OP_AUIPC, `DECD_OP_JAL:
                       legal = 1'b1;
      `DECD_OP_FENCE:  legal = funct3 == 3'b000 || funct3 == 3'b001;
      `DECD_OP_SYSTEM: legal = (funct3 != 3'b000 && funct3 != 3'b100) || (sys_clean && sys_known);
      `DECD_OP_HSTK:   legal = (push_code || pop_code) && hstk_priv;
      default:         legal = 1'b0;
    endcase
  end

  assign ill32     = ~legal;
  assign ipush_vld = push_code && hstk_priv && !fetch_expt;
  assign ipop_vld  = pop_code && hstk_priv && !fetch_expt;

endmodule

`default_nettype wire

//--- src/decd_base_rv32i.sv
/* RV32I base decoder
   Unit select, operand valids and immediate from the major opcode */
`timescale 1ns/1ps
`default_nettype none
`include "decd_defs.svh"

module decd_base_rv32i (
  input  logic [`DECD_INST_W-1:0] inst,
  output decd_pkg::unit_sel_t     unit,
  output logic                    rs1_vld,
  output logic                    rs2_vld,
  output logic                    rd_vld,
  output logic [31:0]             imm,
  output logic                    imm_vld
);
  import decd_pkg::*;

  logic [6:0]  opcode;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = inst[6:0];

  // ====================
  // Immediate formats
  // ====================
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb
  begin
    unit    = UNIT_NONE;
    rs1_vld = 1'b0;
    rs2_vld = 1'b0;
    rd_vld  = 1'b0;
    imm     = 32'h0;
    imm_vld = 1'b0;
    case (opcode)
      `DECD_OP_REG:
      begin
        unit    = UNIT_ALU;
        rs1_vld = 1'b1;
        rs2_vld = 1'b1;
        rd_vld  = 1'b1;
      end
      `DECD_OP_IMM, `DECD_OP_LOAD, `DECD_OP_JALR:
      begin
        unit    = (opcode == `DECD_OP_IMM)  ? UNIT_ALU
                : (opcode == `DECD_OP_LOAD) ? UNIT_LSU : UNIT_BJU;
        rs1_vld = 1'b1;
        rd_vld  = 1'b1;
        imm     = imm_i;
        imm_vld = 1'b1;
      end
      `DECD_OP_STORE, `DECD_OP_BRANCH:
      begin
        unit    = (opcode == `DECD_OP_STORE) ? UNIT_LSU : UNIT_BJU;
        rs1_vld = 1'b1;
        rs2_vld = 1'b1;
        imm     = (opcode == `DECD_OP_STORE) ? imm_s : imm_b;
        imm_vld = 1'b1;
      end
      `DECD_OP_LUI, `DECD_OP_AUIPC:
      begin
        unit    = UNIT_ALU;
        rd_vld  = 1'b1;
        imm     = imm_u;
        imm_vld = 1'b1;
      end
      `DECD_OP_JAL:
      begin
        unit    = UNIT_BJU;
        rd_vld  = 1'b1;
        imm     = imm_j;
        imm_vld = 1'b1;
      end
      `DECD_OP_FENCE, `DECD_OP_SYSTEM:
      begin
        unit    = UNIT_CP0;
        imm     = imm_i;
        imm_vld = 1'b1;
        // CSR access, register source only when funct3[2] is clear
        if (opcode == `DECD_OP_SYSTEM && inst[14:12] != 3'b000)
        begin
          rd_vld  = 1'b1;
          rs1_vld = ~inst[14];
        end
      end
      default:
      begin
        unit = UNIT_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/decd_pkg.sv
/* Decode package
   One-hot unit select and coprocessor function encodings */
`default_nettype none

package decd_pkg;

  // Target execution unit, all zeros when nothing is selected
  typedef enum logic [4:0] {
    UNIT_NONE = 5'b00000,
    UNIT_ALU  = 5'b00001,
    UNIT_BJU  = 5'b00010,
    UNIT_LSU  = 5'b00100,
    UNIT_CP0  = 5'b01000,
    UNIT_XOCC = 5'b10000
  } unit_sel_t;

  // Coprocessor function class
  typedef enum logic [1:0] {
    XOCC_NONE = 2'b00,
    XOCC_NORM = 2'b01,
    XOCC_DLY  = 2'b10
  } xocc_func_t;

  // Sub-function codes, meaning depends on the class
  typedef logic [2:0] xocc_sub_t;

  localparam xocc_sub_t SUB_NONE      = 3'b000;
  // NORM class
  localparam xocc_sub_t SUB_PUSH_RDY  = 3'b001;
  localparam xocc_sub_t SUB_POP_RDY   = 3'b010;
  localparam xocc_sub_t SUB_READ_RSP  = 3'b100;
  // DLY class
  localparam xocc_sub_t SUB_PUSH_CMD  = 3'b001;
  localparam xocc_sub_t SUB_WRITE_CMD = 3'b010;
  localparam xocc_sub_t SUB_POP_RSP   = 3'b100;

endpackage

`default_nettype wire

//--- include/decd_defs.svh
/* Decode stage constants
   Instruction widths, register field positions, opcodes and stack selectors */
`ifndef DECD_DEFS_SVH
`define DECD_DEFS_SVH

`define DECD_INST_W 32
`define DECD_IDX_W  5

// Register field positions
`define DECD_RD_LSB  7
`define DECD_RS1_LSB 15
`define DECD_RS2_LSB 20

// ====================
// Major opcodes
// ====================
`define DECD_OP_LUI    7'b0110111
`define DECD_OP_AUIPC  7'b0010111
`define DECD_OP_JAL    7'b1101111
`define DECD_OP_JALR   7'b1100111
`define DECD_OP_BRANCH 7'b1100011
`define DECD_OP_LOAD   7'b0000011
`define DECD_OP_STORE  7'b0100011
`define DECD_OP_IMM    7'b0010011
`define DECD_OP_REG    7'b0110011
`define DECD_OP_FENCE  7'b0001111
`define DECD_OP_SYSTEM 7'b1110011
`define DECD_OP_XOCC   7'b1011011
`define DECD_OP_HSTK   7'b0001011

// rs2 selectors of the hardware-stack encodings
`define DECD_RS2_IPUSH 5'b00100
`define DECD_RS2_IPOP  5'b00101

`endif
